/* tb.f */
rtl/conv_pipe_pkg.sv
rtl/stream_joiner.sv
rtl/dot_core.sv
rtl/result_collector.sv
rtl/conv_input_top.sv
sim/tb_conv_input_top.sv

/* sim/tb_conv_input_top.sv */
module tb_conv_input_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int units     = 2;
  localparam int cores     = 2;
  localparam int kernel_h  = 3;
  localparam int pix_words = units + kernel_h - 1;

  typedef conv_pipe_pkg::word_t [pix_words-1:0]      pix_beat_t;
  typedef conv_pipe_pkg::word_t [cores*kernel_h-1:0] w_beat_t;
  typedef conv_pipe_pkg::acc_t  [cores*units-1:0]    out_beat_t;

  logic                      aclk;
  logic                      reset;
  logic                      s_pix_valid;
  logic                      s_pix_ready;
  pix_beat_t                 s_pix_data;
  conv_pipe_pkg::beat_ctrl_t s_pix_ctrl;
  logic                      s_w_valid;
  logic                      s_w_ready;
  w_beat_t                   s_w_data;
  logic                      m_valid;
  logic                      m_ready;
  out_beat_t                 m_data;
  logic                      m_last;

  int        seed        = 11;
  int        errors      = 0;
  int        tests_run   = 0;
  int        beats_sent  = 0;
  int        groups_sent = 0;
  int        beats_out   = 0;
  int        ready_thr   = 192;
  string     test_name   = "reset_idle";
  logic      idle_phase  = 1'b0;
  logic      kernel_ok   = 1'b0;
  logic      exp_avail   = 1'b0;
  logic      pop_pending = 1'b0;
  int        col_lens[$];
  out_beat_t exp_q[$];
  logic      exp_last_q[$];
  out_beat_t exp_data;
  logic      exp_last;

  conv_input_top #(
    .units    (units),
    .cores    (cores),
    .kernel_h (kernel_h)
  ) i_dut (
    .aclk        (aclk),
    .reset       (reset),
    .s_pix_valid (s_pix_valid),
    .s_pix_ready (s_pix_ready),
    .s_pix_data  (s_pix_data),
    .s_pix_ctrl  (s_pix_ctrl),
    .s_w_valid   (s_w_valid),
    .s_w_ready   (s_w_ready),
    .s_w_data    (s_w_data),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_data      (m_data),
    .m_last      (m_last)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  // m_ready is drawn at the falling edge and applied after the next rising edge.
  always begin : ready_driver
    logic next_ready;
    @(negedge aclk);
    next_ready = ($random(seed) & 255) < ready_thr;
    @(posedge aclk);
    #0.5;
    m_ready = next_ready;
  end

  // the transfer seen at one falling edge completes at the next rising edge,
  // so the front of the model queue is retired one falling edge later.
  always @(negedge aclk) begin
    if (pop_pending) begin
      beats_out++;
      if (exp_q.size() > 0) begin
        exp_q.delete(0);
        exp_last_q.delete(0);
      end
    end
    exp_avail = exp_q.size() > 0;
    if (exp_avail) begin
      exp_data = exp_q[0];
      exp_last = exp_last_q[0];
    end
    pop_pending = m_valid && m_ready;
  end

  a_idle: assert property (@(posedge aclk) disable iff (reset)
    idle_phase |-> !m_valid && !s_pix_ready && s_w_ready)
    else begin
      errors++;
      $display("[FAIL] %s: expected m_valid=0 s_pix_ready=0 s_w_ready=1 actual %b %b %b",
               test_name, $sampled(m_valid), $sampled(s_pix_ready), $sampled(s_w_ready));
    end

  a_data: assert property (@(posedge aclk) disable iff (reset)
    m_valid && exp_avail |-> m_data == exp_data)
    else begin
      errors++;
      $display("[FAIL] %s: m_data expected %h actual %h", test_name, exp_data, $sampled(m_data));
    end

  a_last: assert property (@(posedge aclk) disable iff (reset)
    m_valid && exp_avail |-> m_last == exp_last)
    else begin
      errors++;
      $display("[FAIL] %s: m_last expected %b actual %b", test_name, exp_last, $sampled(m_last));
    end

  a_extra: assert property (@(posedge aclk) disable iff (reset) m_valid |-> exp_avail)
    else begin
      errors++;
      $display("%s: an output beat appeared that the model did not expect", test_name);
    end

  a_stable: assert property (@(posedge aclk) disable iff (reset)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
    else begin
      errors++;
      $display("%s: the output beat changed or vanished while it was stalled", test_name);
    end

  a_pix_gate: assert property (@(posedge aclk) disable iff (reset) !kernel_ok |-> !s_pix_ready)
    else begin
      errors++;
      $display("%s: pixel ready was high before the kernel was accepted", test_name);
    end

  // about one word in eight is a full-scale value.
  function automatic conv_pipe_pkg::word_t pick_word(input bit extreme);
    int r;
    r = $random(seed);
    if (extreme || (r & 7) == 0) begin
      return r[8] ? 8'sh7f : 8'sh80;
    end
    return conv_pipe_pkg::word_t'(r >>> 9);
  endfunction

  task automatic next_cycle();
    @(posedge aclk);
    #0.5;
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic send_weights(input w_beat_t w);
    beats_sent++;
    s_w_data  = w;
    s_w_valid = 1'b1;
    @(negedge aclk);
    while (!s_w_ready) @(negedge aclk);
    next_cycle();
    s_w_valid = 1'b0;
    kernel_ok = 1'b1;
  endtask

  task automatic send_pixels(input pix_beat_t d, input logic cin_last, input logic last,
                             input bit allow_gap);
    if (allow_gap) begin
      while (($random(seed) & 3) == 0) begin
        s_pix_valid = 1'b0;
        next_cycle();
      end
    end
    beats_sent++;
    s_pix_data          = d;
    s_pix_ctrl.cin_last = cin_last;
    s_pix_ctrl.last     = last;
    s_pix_valid         = 1'b1;
    @(negedge aclk);
    while (!s_pix_ready) @(negedge aclk);
    next_cycle();
    s_pix_valid = 1'b0;
    if (last) begin
      kernel_ok = 1'b0;
    end
  endtask

  // one image has a column per entry of col_lens, each that many channel beats.
  task automatic send_image(input string name, input bit early, input bit extreme);
    w_beat_t   w;
    pix_beat_t b;
    out_beat_t e;
    pix_beat_t beats[$];
    logic      cl_q[$];
    logic      last_q[$];
    int        sums[cores*units];
    int        err_before;
    int        ncols;
    err_before = errors;
    test_name  = name;
    ncols      = col_lens.size();
    for (int i = 0; i < cores * kernel_h; i++) begin
      w[i] = pick_word(extreme);
    end
    for (int col = 0; col < ncols; col++) begin
      for (int i = 0; i < cores * units; i++) begin
        sums[i] = 0;
      end
      for (int ch = 0; ch < col_lens[col]; ch++) begin
        for (int i = 0; i < pix_words; i++) begin
          b[i] = pick_word(extreme);
        end
        for (int c = 0; c < cores; c++) begin
          for (int u = 0; u < units; u++) begin
            for (int k = 0; k < kernel_h; k++) begin
              sums[c*units+u] += int'($signed(b[u+k])) * int'($signed(w[c*kernel_h+k]));
            end
          end
        end
        beats.push_back(b);
        cl_q.push_back(ch == col_lens[col] - 1);
        last_q.push_back(ch == col_lens[col] - 1 && col == ncols - 1);
      end
      for (int i = 0; i < cores * units; i++) begin
        e[i] = conv_pipe_pkg::acc_t'(sums[i]);
      end
      exp_q.push_back(e);
      exp_last_q.push_back(col == ncols - 1);
      groups_sent++;
    end
    // the first pixel beat waits at the input while the joiner still expects a kernel.
    if (early) begin
      s_pix_data          = beats[0];
      s_pix_ctrl.cin_last = cl_q[0];
      s_pix_ctrl.last     = last_q[0];
      s_pix_valid         = 1'b1;
      repeat (6) next_cycle();
    end
    send_weights(w);
    foreach (beats[i]) begin
      send_pixels(beats[i], cl_q[i], last_q[i], !(early && i == 0));
    end
    while (exp_q.size() != 0) @(negedge aclk);
    next_cycle();
    report_test(name, err_before);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 40 * beats_sent + 200) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: no progress after %0d cycles, the run was stopped", cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    s_pix_valid = 1'b0;
    s_pix_data  = '0;
    s_pix_ctrl  = '0;
    s_w_valid   = 1'b0;
    s_w_data    = '0;
    m_ready     = 1'b0;
    repeat (4) @(posedge aclk);
    #0.5;
    reset = 1'b0;

    idle_phase = 1'b1;
    repeat (6) next_cycle();
    idle_phase = 1'b0;
    report_test("reset_idle", 0);

    col_lens = '{2, 2, 2};
    send_image("random_image", 1'b0, 1'b0);
    col_lens = '{1, 4};
    send_image("group_lengths", 1'b0, 1'b0);
    col_lens = '{3, 1, 2};
    send_image("new_kernel", 1'b1, 1'b0);
    ready_thr = 48;
    col_lens  = '{2, 3, 1, 2};
    send_image("backpressure", 1'b0, 1'b1);
    repeat (4) next_cycle();

    a_count: assert (beats_out == groups_sent)
      else begin
        errors++;
        $display("[FAIL] beat_count: expected %0d actual %0d", groups_sent, beats_out);
      end

    $display("%0d tests, %0d groups, %0d output beats, %0d errors",
             tests_run, groups_sent, beats_out, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* rtl/conv_input_top.sv */
module conv_input_top #(
  parameter int units    = 2,
  parameter int cores    = 2,
  parameter int kernel_h = 3
) (
  input  logic                                      aclk,
  input  logic                                      reset,
  input  logic                                      s_pix_valid,
  output logic                                      s_pix_ready,
  input  conv_pipe_pkg::word_t [units+kernel_h-2:0] s_pix_data,
  input  conv_pipe_pkg::beat_ctrl_t                 s_pix_ctrl,
  input  logic                                      s_w_valid,
  output logic                                      s_w_ready,
  input  conv_pipe_pkg::word_t [cores*kernel_h-1:0] s_w_data,
  output logic                                      m_valid,
  input  logic                                      m_ready,
  output conv_pipe_pkg::acc_t  [cores*units-1:0]    m_data,
  output logic                                      m_last
);

  logic                                      pix_valid;
  conv_pipe_pkg::word_t [units+kernel_h-2:0] pix_data;
  conv_pipe_pkg::beat_ctrl_t                 pix_ctrl;
  logic                                      w_load;
  conv_pipe_pkg::word_t [cores*kernel_h-1:0] w_data;
  logic                 [cores-1:0]          core_ready;
  logic                 [cores-1:0]          res_valid;
  logic                 [cores-1:0]          res_last;
  conv_pipe_pkg::acc_t  [cores*units-1:0]    res_data;
  logic                                      res_ready;

  stream_joiner #(
    .units    (units),
    .cores    (cores),
    .kernel_h (kernel_h)
  ) u_joiner (
    .aclk        (aclk),
    .reset       (reset),
    .s_pix_valid (s_pix_valid),
    .s_pix_data  (s_pix_data),
    .s_pix_ctrl  (s_pix_ctrl),
    .s_w_valid   (s_w_valid),
    .s_w_data    (s_w_data),
    .core_ready  (core_ready),
    .s_pix_ready (s_pix_ready),
    .s_w_ready   (s_w_ready),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .pix_ctrl    (pix_ctrl),
    .w_load      (w_load),
    .w_data      (w_data)
  );

  // core c owns output channel c, its kernel column and its slice of the result bus.
  for (genvar c = 0; c < cores; c++) begin : g_core
    dot_core #(
      .units    (units),
      .kernel_h (kernel_h)
    ) u_core (
      .aclk       (aclk),
      .reset      (reset),
      .w_load     (w_load),
      .w_data     (w_data[c*kernel_h +: kernel_h]),
      .pix_valid  (pix_valid),
      .pix_data   (pix_data),
      .pix_ctrl   (pix_ctrl),
      .res_ready  (res_ready),
      .core_ready (core_ready[c]),
      .res_valid  (res_valid[c]),
      .res_data   (res_data[c*units +: units]),
      .res_last   (res_last[c])
    );
  end

  result_collector #(
    .units (units),
    .cores (cores)
  ) u_collector (
    .aclk      (aclk),
    .reset     (reset),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_last  (res_last[0]),
    .m_ready   (m_ready),
    .res_ready (res_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_last    (m_last)
  );

endmodule

/* rtl/result_collector.sv */
module result_collector #(
  parameter int units = 2,
  parameter int cores = 2
) (
  input  logic                                    aclk,
  input  logic                                    reset,
  input  logic                [cores-1:0]         res_valid,
  input  conv_pipe_pkg::acc_t [cores*units-1:0]   res_data,
  input  logic                                    res_last,
  input  logic                                    m_ready,
  output logic                                    res_ready,
  output logic                                    m_valid,
  output conv_pipe_pkg::acc_t [cores*units-1:0]   m_data,
  output logic                                    m_last
);

  logic all_valid;
  logic load;

  assign all_valid = &res_valid;

  // take the results when the output register is empty or drains this cycle.
  assign load      = all_valid && (!m_valid || m_ready);
  assign res_ready = load;

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (load) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  // all cores see the same beats, so core 0 speaks for the last flag.
  always_ff @(posedge aclk) begin
    if (load) begin
      m_data <= res_data;
      m_last <= res_last;
    end
  end

endmodule

/* rtl/dot_core.sv */
module dot_core #(
  parameter int units    = 2,
  parameter int kernel_h = 3
) (
  input  logic                                      aclk,
  input  logic                                      reset,
  input  logic                                      w_load,
  input  conv_pipe_pkg::word_t [kernel_h-1:0]       w_data,
  input  logic                                      pix_valid,
  input  conv_pipe_pkg::word_t [units+kernel_h-2:0] pix_data,
  input  conv_pipe_pkg::beat_ctrl_t                 pix_ctrl,
  input  logic                                      res_ready,
  output logic                                      core_ready,
  output logic                                      res_valid,
  output conv_pipe_pkg::acc_t  [units-1:0]          res_data,
  output logic                                      res_last
);

  conv_pipe_pkg::word_t [kernel_h-1:0] kern;
  conv_pipe_pkg::acc_t  [units-1:0]    col_sum;
  conv_pipe_pkg::acc_t  [units-1:0]    s1_sum;
  conv_pipe_pkg::acc_t  [units-1:0]    acc;
  conv_pipe_pkg::beat_ctrl_t           s1_ctrl;
  logic                                s1_valid;
  logic                                hold;
  logic                                s1_done;

  always_ff @(posedge aclk) begin
    if (w_load) begin
      kern <= w_data;
    end
  end

  // unit u sees rows u to u+kernel_h-1 of the beat.
  always_comb begin
    for (int u = 0; u < units; u++) begin
      col_sum[u] = '0;
      for (int k = 0; k < kernel_h; k++) begin
        col_sum[u] = col_sum[u]
                   + conv_pipe_pkg::acc_t'($signed(pix_data[u+k]))
                   * conv_pipe_pkg::acc_t'($signed(kern[k]));
      end
    end
  end

  // a closing beat in stage one waits while the result register is still full.
  assign hold    = s1_valid && s1_ctrl.cin_last && res_valid && !res_ready;
  assign s1_done = s1_valid && !hold;

  // not dependent on res_ready, so the ready path stays short.
  assign core_ready = !(res_valid && s1_valid && s1_ctrl.cin_last);

  always_ff @(posedge aclk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (!hold) begin
      s1_valid <= pix_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (pix_valid && !hold) begin
      s1_sum  <= col_sum;
      s1_ctrl <= pix_ctrl;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      acc       <= '0;
      res_valid <= 1'b0;
    end else if (s1_done && s1_ctrl.cin_last) begin
      acc       <= '0;
      res_valid <= 1'b1;
    end else begin
      if (s1_done) begin
        for (int u = 0; u < units; u++) begin
          acc[u] <= acc[u] + s1_sum[u];
        end
      end
      if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s1_done && s1_ctrl.cin_last) begin
      for (int u = 0; u < units; u++) begin
        res_data[u] <= acc[u] + s1_sum[u];
      end
      res_last <= s1_ctrl.last;
    end
  end

endmodule

/* rtl/stream_joiner.sv */
module stream_joiner #(
  parameter int units    = 2,
  parameter int cores    = 2,
  parameter int kernel_h = 3
) (
  input  logic                                             aclk,
  input  logic                                             reset,
  input  logic                                             s_pix_valid,
  input  conv_pipe_pkg::word_t [units+kernel_h-2:0]        s_pix_data,
  input  conv_pipe_pkg::beat_ctrl_t                        s_pix_ctrl,
  input  logic                                             s_w_valid,
  input  conv_pipe_pkg::word_t [cores*kernel_h-1:0]        s_w_data,
  input  logic                 [cores-1:0]                 core_ready,
  output logic                                             s_pix_ready,
  output logic                                             s_w_ready,
  output logic                                             pix_valid,
  output conv_pipe_pkg::word_t [units+kernel_h-2:0]        pix_data,
  output conv_pipe_pkg::beat_ctrl_t                        pix_ctrl,
  output logic                                             w_load,
  output conv_pipe_pkg::word_t [cores*kernel_h-1:0]        w_data
);

  localparam int pix_words = units + kernel_h - 1;

  conv_pipe_pkg::join_state_t state;
  logic                       w_take;
  logic                       pix_take;

  assign s_w_ready = (state == conv_pipe_pkg::join_load);
  assign w_take    = s_w_valid && s_w_ready;

  // the cores latch the new kernel while w_load is high, so no pixel
  // beat may enter in that cycle.
  assign s_pix_ready = (state == conv_pipe_pkg::join_run) && !w_load && (&core_ready);
  assign pix_take    = s_pix_valid && s_pix_ready;

  // cores see only real transfers, so a core never takes a beat that
  // another core has refused.
  assign pix_valid = pix_take;
  assign pix_data  = s_pix_data[pix_words-1:0];
  assign pix_ctrl  = s_pix_ctrl;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state  <= conv_pipe_pkg::join_load;
      w_load <= 1'b0;
    end else begin
      w_load <= w_take;
      case (state)
        conv_pipe_pkg::join_load: begin
          if (w_take) begin
            state <= conv_pipe_pkg::join_run;
          end
        end
        conv_pipe_pkg::join_run: begin
          if (pix_take && s_pix_ctrl.last) begin
            state <= conv_pipe_pkg::join_load;
          end
        end
        default: begin
          state <= conv_pipe_pkg::join_load;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (w_take) begin
      w_data <= s_w_data;
    end
  end

endmodule

/* rtl/conv_pipe_pkg.sv */
package conv_pipe_pkg;

  // pixel and weight words are signed fixed point.
  localparam int word_w = 8;

  // wide enough for a full column of products summed over many input channels.
  localparam int acc_w = 24;

  typedef logic signed [word_w-1:0] word_t;

  typedef logic signed [acc_w-1:0] acc_t;

  // sideband of a pixel beat.
  // cin_last closes the accumulation group of one column.
  // last closes the image.
  typedef struct packed {
    logic cin_last;
    logic last;
  } beat_ctrl_t;

  // the joiner waits for a kernel in join_load and passes pixels in join_run.
  typedef enum logic {
    join_load,
    join_run
  } join_state_t;

endpackage
